// File: la_core_pkg.sv
package la_core_pkg;

    localparam int XLEN    = 32;
    localparam int GPR_NUM = 32;
    localparam int REG_AW  = $clog2(GPR_NUM);

    // 3R opcodes sit in instr[31:15]
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_SLT   = 17'h00024;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002a;
    localparam logic [16:0] OPC_XOR   = 17'h0002b;

    // 2RI12 opcodes sit in instr[31:22]
    localparam logic [9:0] OPC_SLTI   = 10'h008;
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;
    localparam logic [9:0] OPC_ANDI   = 10'h00d;
    localparam logic [9:0] OPC_ORI    = 10'h00e;
    localparam logic [9:0] OPC_XORI   = 10'h00f;
    localparam logic [9:0] OPC_LD_W   = 10'h0a2;
    localparam logic [9:0] OPC_ST_W   = 10'h0a6;

    // 2RI14 opcodes sit in instr[31:24]
    localparam logic [7:0] OPC_LL_W = 8'h20;
    localparam logic [7:0] OPC_SC_W = 8'h21;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_LL, ALU_SC, ALU_LD, ALU_ST
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_ARITH, SEL_LOGIC, SEL_LOAD, SEL_STORE, SEL_MOVE
    } alu_sel_e;

    typedef enum logic [2:0] {
        MEM_NONE, MEM_LOAD, MEM_STORE, MEM_LL, MEM_SC
    } mem_op_e;

    typedef struct packed {
        logic [16:0]       opcode;
        logic [REG_AW-1:0] rk;
        logic [REG_AW-1:0] rj;
        logic [REG_AW-1:0] rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]        opcode;
        logic [11:0]       imm12;
        logic [REG_AW-1:0] rj;
        logic [REG_AW-1:0] rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [7:0]        opcode;
        logic [13:0]       imm14;
        logic [REG_AW-1:0] rj;
        logic [REG_AW-1:0] rd;
    } fmt_2ri14_t;

    // same instruction word seen through each format
    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
        fmt_2ri14_t fmt_2ri14;
    } instr_fmt_u;

endpackage

// File: decode_if.sv
`timescale 1ns/1ns

// one decoded instruction on its way from decode to execute
interface decode_if;

    logic                           valid;
    logic                           illegal;
    la_core_pkg::alu_op_e           aluop;
    la_core_pkg::alu_sel_e          alusel;
    la_core_pkg::mem_op_e           memop;
    logic [la_core_pkg::XLEN-1:0]   opa;
    logic [la_core_pkg::XLEN-1:0]   opb;
    logic [la_core_pkg::XLEN-1:0]   imm;
    logic                           write_valid;
    logic [la_core_pkg::REG_AW-1:0] write_addr;
    // rd value for ST.W and SC.W
    logic [la_core_pkg::XLEN-1:0]   store_data;

    modport master (
        output valid, illegal, aluop, alusel, memop, opa, opb, imm,
               write_valid, write_addr, store_data
    );

    modport slave (
        input valid, illegal, aluop, alusel, memop, opa, opb, imm,
              write_valid, write_addr, store_data
    );

endinterface

// File: decoder_2ri14.sv
`timescale 1ns/1ns

// LL.W and SC.W, layout {opcode[8], imm14, rj, rd}
module decoder_2ri14 (
    input  la_core_pkg::instr_fmt_u        instr_i,
    output logic                           claim_o,
    output logic [1:0]                     read_valid_o,
    output logic [la_core_pkg::XLEN-1:0]   imm_o,
    output logic                           write_valid_o,
    output logic [la_core_pkg::REG_AW-1:0] write_addr_o,
    output la_core_pkg::alu_op_e           aluop_o,
    output la_core_pkg::alu_sel_e          alusel_o,
    output la_core_pkg::mem_op_e           memop_o
);

    la_core_pkg::fmt_2ri14_t f;

    assign f = instr_i.fmt_2ri14;

    // word offset, sign extended then shifted by two
    assign imm_o = {{(la_core_pkg::XLEN-16){f.imm14[13]}}, f.imm14, 2'b00};

    always_comb begin
        claim_o       = 1'b1;
        read_valid_o  = 2'b11;
        write_valid_o = 1'b1;
        write_addr_o  = f.rd;
        aluop_o       = la_core_pkg::ALU_LL;
        alusel_o      = la_core_pkg::SEL_MOVE;
        memop_o       = la_core_pkg::MEM_NONE;
        case (f.opcode)
            la_core_pkg::OPC_LL_W: begin
                read_valid_o = 2'b01;
                memop_o      = la_core_pkg::MEM_LL;
            end
            // rd is both the store data and the success flag target
            la_core_pkg::OPC_SC_W: begin
                aluop_o = la_core_pkg::ALU_SC;
                memop_o = la_core_pkg::MEM_SC;
            end
            default: begin
                claim_o       = 1'b0;
                read_valid_o  = 2'b00;
                write_valid_o = 1'b0;
            end
        endcase
    end

endmodule

// File: decoder_2ri12.sv
`timescale 1ns/1ns

// register-immediate ops and word loads/stores
module decoder_2ri12 (
    input  la_core_pkg::instr_fmt_u        instr_i,
    output logic                           claim_o,
    output logic [1:0]                     read_valid_o,
    output logic [la_core_pkg::XLEN-1:0]   imm_o,
    output logic                           write_valid_o,
    output logic [la_core_pkg::REG_AW-1:0] write_addr_o,
    output la_core_pkg::alu_op_e           aluop_o,
    output la_core_pkg::alu_sel_e          alusel_o,
    output la_core_pkg::mem_op_e           memop_o
);

    la_core_pkg::fmt_2ri12_t f;
    logic                    zext;

    assign f = instr_i.fmt_2ri12;

    // logic immediates are zero extended
    assign imm_o = zext ? {{(la_core_pkg::XLEN-12){1'b0}}, f.imm12}
                        : {{(la_core_pkg::XLEN-12){f.imm12[11]}}, f.imm12};

    always_comb begin
        claim_o       = 1'b1;
        read_valid_o  = 2'b01;
        write_valid_o = 1'b1;
        write_addr_o  = f.rd;
        aluop_o       = la_core_pkg::ALU_ADD;
        alusel_o      = la_core_pkg::SEL_ARITH;
        memop_o       = la_core_pkg::MEM_NONE;
        zext          = 1'b0;
        case (f.opcode)
            la_core_pkg::OPC_ADDI_W: ;
            la_core_pkg::OPC_SLTI: aluop_o = la_core_pkg::ALU_SLT;
            la_core_pkg::OPC_ANDI: begin
                aluop_o  = la_core_pkg::ALU_AND;
                alusel_o = la_core_pkg::SEL_LOGIC;
                zext     = 1'b1;
            end
            la_core_pkg::OPC_ORI: begin
                aluop_o  = la_core_pkg::ALU_OR;
                alusel_o = la_core_pkg::SEL_LOGIC;
                zext     = 1'b1;
            end
            la_core_pkg::OPC_XORI: begin
                aluop_o  = la_core_pkg::ALU_XOR;
                alusel_o = la_core_pkg::SEL_LOGIC;
                zext     = 1'b1;
            end
            la_core_pkg::OPC_LD_W: begin
                aluop_o  = la_core_pkg::ALU_LD;
                alusel_o = la_core_pkg::SEL_LOAD;
                memop_o  = la_core_pkg::MEM_LOAD;
            end
            // store reads rd as data and writes nothing back
            la_core_pkg::OPC_ST_W: begin
                aluop_o       = la_core_pkg::ALU_ST;
                alusel_o      = la_core_pkg::SEL_STORE;
                memop_o       = la_core_pkg::MEM_STORE;
                read_valid_o  = 2'b11;
                write_valid_o = 1'b0;
                write_addr_o  = '0;
            end
            default: begin
                claim_o       = 1'b0;
                read_valid_o  = 2'b00;
                write_valid_o = 1'b0;
            end
        endcase
    end

endmodule

// File: decoder_3r.sv
`timescale 1ns/1ns

// register-register ops, layout {opcode[17], rk, rj, rd}
module decoder_3r (
    input  la_core_pkg::instr_fmt_u        instr_i,
    output logic                           claim_o,
    output logic [1:0]                     read_valid_o,
    output logic                           write_valid_o,
    output logic [la_core_pkg::REG_AW-1:0] write_addr_o,
    output la_core_pkg::alu_op_e           aluop_o,
    output la_core_pkg::alu_sel_e          alusel_o,
    output la_core_pkg::mem_op_e           memop_o
);

    la_core_pkg::fmt_3r_t f;

    assign f            = instr_i.fmt_3r;
    assign read_valid_o = claim_o ? 2'b11 : 2'b00;
    assign write_valid_o = claim_o;
    assign write_addr_o = f.rd;
    assign memop_o      = la_core_pkg::MEM_NONE;

    always_comb begin
        claim_o  = 1'b1;
        aluop_o  = la_core_pkg::ALU_ADD;
        alusel_o = la_core_pkg::SEL_ARITH;
        case (f.opcode)
            la_core_pkg::OPC_ADD_W: ;
            la_core_pkg::OPC_SUB_W: aluop_o = la_core_pkg::ALU_SUB;
            la_core_pkg::OPC_SLT:   aluop_o = la_core_pkg::ALU_SLT;
            la_core_pkg::OPC_AND: begin
                aluop_o  = la_core_pkg::ALU_AND;
                alusel_o = la_core_pkg::SEL_LOGIC;
            end
            la_core_pkg::OPC_OR: begin
                aluop_o  = la_core_pkg::ALU_OR;
                alusel_o = la_core_pkg::SEL_LOGIC;
            end
            la_core_pkg::OPC_XOR: begin
                aluop_o  = la_core_pkg::ALU_XOR;
                alusel_o = la_core_pkg::SEL_LOGIC;
            end
            default: claim_o = 1'b0;
        endcase
    end

endmodule

// File: gpr_file.sv
`timescale 1ns/1ns

module gpr_file (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic [la_core_pkg::REG_AW-1:0] raddr_a_i,
    input  logic [la_core_pkg::REG_AW-1:0] raddr_b_i,
    output logic [la_core_pkg::XLEN-1:0]   rdata_a_o,
    output logic [la_core_pkg::XLEN-1:0]   rdata_b_o,
    input  logic                           we_i,
    input  logic [la_core_pkg::REG_AW-1:0] waddr_i,
    input  logic [la_core_pkg::XLEN-1:0]   wdata_i
);

    logic [la_core_pkg::XLEN-1:0] regs [la_core_pkg::GPR_NUM];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < la_core_pkg::GPR_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 is hardwired to zero, same-cycle writes bypass to the readers
    assign rdata_a_o = (raddr_a_i == '0)                   ? '0 :
                       (we_i && waddr_i == raddr_a_i)      ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0)                   ? '0 :
                       (we_i && waddr_i == raddr_b_i)      ? wdata_i : regs[raddr_b_i];

endmodule

// File: decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           issue_i,
    input  la_core_pkg::instr_fmt_u        instr_i,
    output logic [la_core_pkg::REG_AW-1:0] gpr_raddr_a_o,
    output logic [la_core_pkg::REG_AW-1:0] gpr_raddr_b_o,
    input  logic [la_core_pkg::XLEN-1:0]   gpr_rdata_a_i,
    input  logic [la_core_pkg::XLEN-1:0]   gpr_rdata_b_i,
    decode_if.master                       dec_o
);

    logic                           claim_14, claim_12, claim_3r, any_claim;
    logic [1:0]                     rv_14, rv_12, rv_3r, read_valid;
    logic [la_core_pkg::XLEN-1:0]   imm_14, imm_12, imm;
    logic                           wv_14, wv_12, wv_3r, write_valid;
    logic [la_core_pkg::REG_AW-1:0] wa_14, wa_12, wa_3r, write_addr;
    la_core_pkg::alu_op_e           op_14, op_12, op_3r, aluop;
    la_core_pkg::alu_sel_e          sel_14, sel_12, sel_3r, alusel;
    la_core_pkg::mem_op_e           mem_14, mem_12, mem_3r, memop;

    decoder_2ri14 u_dec_2ri14 (
        .instr_i(instr_i), .claim_o(claim_14), .read_valid_o(rv_14), .imm_o(imm_14),
        .write_valid_o(wv_14), .write_addr_o(wa_14), .aluop_o(op_14),
        .alusel_o(sel_14), .memop_o(mem_14)
    );

    decoder_2ri12 u_dec_2ri12 (
        .instr_i(instr_i), .claim_o(claim_12), .read_valid_o(rv_12), .imm_o(imm_12),
        .write_valid_o(wv_12), .write_addr_o(wa_12), .aluop_o(op_12),
        .alusel_o(sel_12), .memop_o(mem_12)
    );

    decoder_3r u_dec_3r (
        .instr_i(instr_i), .claim_o(claim_3r), .read_valid_o(rv_3r),
        .write_valid_o(wv_3r), .write_addr_o(wa_3r), .aluop_o(op_3r),
        .alusel_o(sel_3r), .memop_o(mem_3r)
    );

    assign any_claim = claim_14 | claim_12 | claim_3r;

    // rj and rd share their bit positions in every format
    assign gpr_raddr_a_o = instr_i.fmt_3r.rj;
    assign gpr_raddr_b_o = claim_3r ? instr_i.fmt_3r.rk : instr_i.fmt_3r.rd;

    // formats never overlap so at most one decoder claims
    always_comb begin
        read_valid  = rv_14;
        imm         = imm_14;
        write_valid = wv_14;
        write_addr  = wa_14;
        aluop       = op_14;
        alusel      = sel_14;
        memop       = mem_14;
        if (claim_3r) begin
            read_valid  = rv_3r;
            imm         = '0;
            write_valid = wv_3r;
            write_addr  = wa_3r;
            aluop       = op_3r;
            alusel      = sel_3r;
            memop       = mem_3r;
        end else if (claim_12) begin
            read_valid  = rv_12;
            imm         = imm_12;
            write_valid = wv_12;
            write_addr  = wa_12;
            aluop       = op_12;
            alusel      = sel_12;
            memop       = mem_12;
        end else if (!claim_14) begin
            write_valid = 1'b0;
            memop       = la_core_pkg::MEM_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dec_o.valid   <= 1'b0;
            dec_o.illegal <= 1'b0;
        end else begin
            dec_o.valid   <= issue_i;
            dec_o.illegal <= issue_i & ~any_claim;
        end
    end

    // unread operands are zeroed so execute can OR in the immediate
    always_ff @(posedge clk) begin
        dec_o.aluop       <= aluop;
        dec_o.alusel      <= alusel;
        dec_o.memop       <= memop;
        dec_o.opa         <= read_valid[0] ? gpr_rdata_a_i : '0;
        dec_o.opb         <= read_valid[1] ? gpr_rdata_b_i : '0;
        dec_o.imm         <= imm;
        dec_o.write_valid <= write_valid;
        dec_o.write_addr  <= write_addr;
        dec_o.store_data  <= gpr_rdata_b_i;
    end

endmodule

// File: alu_execute.sv
`timescale 1ns/1ns

module alu_execute (
    input  logic                           clk,
    input  logic                           rst_n_i,
    decode_if.slave                        dec_i,
    output logic                           valid_o,
    output logic                           illegal_o,
    output logic [la_core_pkg::XLEN-1:0]   alu_result_o,
    output logic [la_core_pkg::XLEN-1:0]   store_data_o,
    output la_core_pkg::mem_op_e           memop_o,
    output logic                           write_valid_o,
    output logic [la_core_pkg::REG_AW-1:0] write_addr_o
);

    logic [la_core_pkg::XLEN-1:0] op_b;
    logic [la_core_pkg::XLEN-1:0] arith_res;
    logic [la_core_pkg::XLEN-1:0] logic_res;

    // only one of opb and imm is nonzero for ALU ops
    assign op_b = dec_i.opb | dec_i.imm;

    always_comb begin
        case (dec_i.aluop)
            la_core_pkg::ALU_ADD: arith_res = dec_i.opa + op_b;
            la_core_pkg::ALU_SUB: arith_res = dec_i.opa - op_b;
            la_core_pkg::ALU_SLT: begin
                arith_res = {{(la_core_pkg::XLEN-1){1'b0}},
                             ($signed(dec_i.opa) < $signed(op_b))};
            end
            // memory ops use rj plus offset as address
            default: arith_res = dec_i.opa + dec_i.imm;
        endcase
    end

    always_comb begin
        case (dec_i.aluop)
            la_core_pkg::ALU_AND: logic_res = dec_i.opa & op_b;
            la_core_pkg::ALU_OR:  logic_res = dec_i.opa | op_b;
            default:              logic_res = dec_i.opa ^ op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o   <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            valid_o   <= dec_i.valid;
            illegal_o <= dec_i.illegal;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_o  <= (dec_i.alusel == la_core_pkg::SEL_LOGIC) ? logic_res : arith_res;
        store_data_o  <= dec_i.store_data;
        memop_o       <= dec_i.memop;
        write_valid_o <= dec_i.write_valid;
        write_addr_o  <= dec_i.write_addr;
    end

endmodule

// File: result_stage.sv
`timescale 1ns/1ns

module result_stage #(
    parameter int MEM_WORDS = 64
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           valid_i,
    input  logic                           illegal_i,
    input  logic [la_core_pkg::XLEN-1:0]   alu_result_i,
    input  logic [la_core_pkg::XLEN-1:0]   store_data_i,
    input  la_core_pkg::mem_op_e           memop_i,
    input  logic                           write_valid_i,
    input  logic [la_core_pkg::REG_AW-1:0] write_addr_i,
    output logic                           gpr_we_o,
    output logic [la_core_pkg::REG_AW-1:0] gpr_waddr_o,
    output logic [la_core_pkg::XLEN-1:0]   gpr_wdata_o,
    output logic                           retire_valid_o,
    output logic [la_core_pkg::REG_AW-1:0] retire_addr_o,
    output logic [la_core_pkg::XLEN-1:0]   retire_data_o,
    output logic                           illegal_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [la_core_pkg::XLEN-1:0] mem [MEM_WORDS];
    logic                         ll_bit;
    logic [IDX_W-1:0]             idx;
    logic                         mem_we;
    logic [la_core_pkg::XLEN-1:0] wb_data;

    // word index, byte offset bits dropped
    assign idx = alu_result_i[IDX_W+1:2];

    // SC.W only stores while the link is held
    assign mem_we = valid_i && (memop_i == la_core_pkg::MEM_STORE ||
                                (memop_i == la_core_pkg::MEM_SC && ll_bit));

    always_comb begin
        case (memop_i)
            la_core_pkg::MEM_LOAD, la_core_pkg::MEM_LL: wb_data = mem[idx];
            la_core_pkg::MEM_SC: wb_data = {{(la_core_pkg::XLEN-1){1'b0}}, ll_bit};
            default: wb_data = alu_result_i;
        endcase
    end

    assign gpr_we_o    = valid_i & write_valid_i;
    assign gpr_waddr_o = write_addr_i;
    assign gpr_wdata_o = wb_data;

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[idx] <= store_data_i;
        end
    end

    // set by LL.W, dropped by any store or SC.W
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ll_bit <= 1'b0;
        end else if (valid_i && memop_i == la_core_pkg::MEM_LL) begin
            ll_bit <= 1'b1;
        end else if (valid_i && (memop_i == la_core_pkg::MEM_SC ||
                                 memop_i == la_core_pkg::MEM_STORE)) begin
            ll_bit <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retire_valid_o <= 1'b0;
            illegal_o      <= 1'b0;
        end else begin
            retire_valid_o <= valid_i & write_valid_i;
            illegal_o      <= valid_i & illegal_i;
        end
    end

    always_ff @(posedge clk) begin
        retire_addr_o <= write_addr_i;
        retire_data_o <= wb_data;
    end

endmodule

// File: la_exec_top.sv
`timescale 1ns/1ns

module la_exec_top #(
    parameter int MEM_WORDS = 64
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           issue_i,
    input  logic [la_core_pkg::XLEN-1:0]   instr_i,
    output logic                           retire_valid_o,
    output logic [la_core_pkg::REG_AW-1:0] retire_addr_o,
    output logic [la_core_pkg::XLEN-1:0]   retire_data_o,
    output logic                           illegal_o
);

    logic [la_core_pkg::REG_AW-1:0] raddr_a, raddr_b, waddr, ex_write_addr;
    logic [la_core_pkg::XLEN-1:0]   rdata_a, rdata_b, wdata;
    logic [la_core_pkg::XLEN-1:0]   ex_result, ex_store_data;
    logic                           we, ex_valid, ex_illegal, ex_write_valid;
    la_core_pkg::mem_op_e           ex_memop;

    decode_if u_dec_if ();

    gpr_file u_gpr (
        .clk(clk), .rst_n_i(rst_n_i),
        .raddr_a_i(raddr_a), .raddr_b_i(raddr_b),
        .rdata_a_o(rdata_a), .rdata_b_o(rdata_b),
        .we_i(we), .waddr_i(waddr), .wdata_i(wdata)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n_i(rst_n_i), .issue_i(issue_i), .instr_i(instr_i),
        .gpr_raddr_a_o(raddr_a), .gpr_raddr_b_o(raddr_b),
        .gpr_rdata_a_i(rdata_a), .gpr_rdata_b_i(rdata_b),
        .dec_o(u_dec_if.master)
    );

    alu_execute u_execute (
        .clk(clk), .rst_n_i(rst_n_i), .dec_i(u_dec_if.slave),
        .valid_o(ex_valid), .illegal_o(ex_illegal),
        .alu_result_o(ex_result), .store_data_o(ex_store_data), .memop_o(ex_memop),
        .write_valid_o(ex_write_valid), .write_addr_o(ex_write_addr)
    );

    result_stage #(
        .MEM_WORDS(MEM_WORDS)
    ) u_result (
        .clk(clk), .rst_n_i(rst_n_i),
        .valid_i(ex_valid), .illegal_i(ex_illegal),
        .alu_result_i(ex_result), .store_data_i(ex_store_data), .memop_i(ex_memop),
        .write_valid_i(ex_write_valid), .write_addr_i(ex_write_addr),
        .gpr_we_o(we), .gpr_waddr_o(waddr), .gpr_wdata_o(wdata),
        .retire_valid_o(retire_valid_o), .retire_addr_o(retire_addr_o),
        .retire_data_o(retire_data_o), .illegal_o(illegal_o)
    );

endmodule

// File: tb_la_exec_top.sv
`timescale 1ns/1ns

module tb_la_exec_top;

    localparam int XLEN      = la_core_pkg::XLEN;
    localparam int AW        = la_core_pkg::REG_AW;
    localparam int MEM_WORDS = 64;
    localparam int IDX_HI    = $clog2(MEM_WORDS) + 1;

    logic            clk;
    logic            rst_n_i;
    logic            issue_i;
    logic [XLEN-1:0] instr_i;
    logic            retire_valid_o;
    logic [AW-1:0]   retire_addr_o;
    logic [XLEN-1:0] retire_data_o;
    logic            illegal_o;

    // stimulus table with the retire each entry should produce
    logic [XLEN-1:0] tbl_instr[$];
    logic            tbl_wr[$];
    logic [AW-1:0]   tbl_addr[$];
    logic [XLEN-1:0] tbl_data[$];
    logic            tbl_ill[$];

    // reference model state
    logic [XLEN-1:0] ref_regs [32];
    logic [XLEN-1:0] ref_mem [MEM_WORDS];
    logic            ref_ll;

    // outstanding events and the cycle each one is due
    int unsigned     ret_due_q[$];
    logic [AW-1:0]   ret_addr_q[$];
    logic [XLEN-1:0] ret_data_q[$];
    int unsigned     ill_due_q[$];

    logic [31:0]     lfsr_state;
    int unsigned     cycle;
    int              retire_errs;
    int              illegal_errs;
    logic            built;

    la_exec_top #(
        .MEM_WORDS(MEM_WORDS)
    ) u_dut (
        .clk(clk), .rst_n_i(rst_n_i), .issue_i(issue_i), .instr_i(instr_i),
        .retire_valid_o(retire_valid_o), .retire_addr_o(retire_addr_o),
        .retire_data_o(retire_data_o), .illegal_o(illegal_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [11:0] rand_imm12();
        logic [11:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < 12; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[10:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_3r(input logic [16:0] opc,
                                           input logic [4:0] rk, rj, rd);
        return {opc, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri12(input logic [9:0] opc, input logic [11:0] imm,
                                              input logic [4:0] rj, rd);
        return {opc, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri14(input logic [7:0] opc, input logic [13:0] imm,
                                              input logic [4:0] rj, rd);
        return {opc, imm, rj, rd};
    endfunction

    // runs one instruction on the model and appends it to the table
    task automatic add_entry(input logic [31:0] w);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] simm;
        logic [XLEN-1:0] zimm;
        logic [XLEN-1:0] oimm;
        logic [XLEN-1:0] res;
        logic [XLEN-1:0] addr;
        logic            wr;
        logic            ill;
        a    = ref_regs[w[9:5]];
        b    = ref_regs[w[14:10]];
        simm = {{20{w[21]}}, w[21:10]};
        zimm = {20'h0, w[21:10]};
        oimm = {{16{w[23]}}, w[23:10], 2'b00};
        wr   = 1'b1;
        ill  = 1'b0;
        res  = '0;
        if (w[31:15] == la_core_pkg::OPC_ADD_W) begin
            res = a + b;
        end else if (w[31:15] == la_core_pkg::OPC_SUB_W) begin
            res = a - b;
        end else if (w[31:15] == la_core_pkg::OPC_SLT) begin
            res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        end else if (w[31:15] == la_core_pkg::OPC_AND) begin
            res = a & b;
        end else if (w[31:15] == la_core_pkg::OPC_OR) begin
            res = a | b;
        end else if (w[31:15] == la_core_pkg::OPC_XOR) begin
            res = a ^ b;
        end else if (w[31:22] == la_core_pkg::OPC_ADDI_W) begin
            res = a + simm;
        end else if (w[31:22] == la_core_pkg::OPC_SLTI) begin
            res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
        end else if (w[31:22] == la_core_pkg::OPC_ANDI) begin
            res = a & zimm;
        end else if (w[31:22] == la_core_pkg::OPC_ORI) begin
            res = a | zimm;
        end else if (w[31:22] == la_core_pkg::OPC_XORI) begin
            res = a ^ zimm;
        end else if (w[31:22] == la_core_pkg::OPC_LD_W) begin
            addr = a + simm;
            res  = ref_mem[addr[IDX_HI:2]];
        end else if (w[31:22] == la_core_pkg::OPC_ST_W) begin
            addr                  = a + simm;
            ref_mem[addr[IDX_HI:2]] = ref_regs[w[4:0]];
            ref_ll                = 1'b0;
            wr                    = 1'b0;
        end else if (w[31:24] == la_core_pkg::OPC_LL_W) begin
            addr   = a + oimm;
            res    = ref_mem[addr[IDX_HI:2]];
            ref_ll = 1'b1;
        end else if (w[31:24] == la_core_pkg::OPC_SC_W) begin
            addr = a + oimm;
            if (ref_ll) begin
                ref_mem[addr[IDX_HI:2]] = ref_regs[w[4:0]];
            end
            res    = {31'h0, ref_ll};
            ref_ll = 1'b0;
        end else begin
            wr  = 1'b0;
            ill = 1'b1;
        end
        if (wr && w[4:0] != 5'd0) begin
            ref_regs[w[4:0]] = res;
        end
        tbl_instr.push_back(w);
        tbl_wr.push_back(wr);
        tbl_addr.push_back(w[4:0]);
        tbl_data.push_back(res);
        tbl_ill.push_back(ill);
    endtask

    task automatic build_table();
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        ref_ll = 1'b0;
        for (int i = 1; i <= 4; i++) begin
            add_entry(enc_2ri12(la_core_pkg::OPC_ADDI_W, rand_imm12(), 5'd0, 5'(i)));
        end
        add_entry(enc_3r(la_core_pkg::OPC_ADD_W, 5'd2, 5'd1, 5'd5));
        add_entry(enc_3r(la_core_pkg::OPC_SUB_W, 5'd2, 5'd1, 5'd6));
        add_entry(enc_3r(la_core_pkg::OPC_AND, 5'd2, 5'd1, 5'd7));
        add_entry(enc_3r(la_core_pkg::OPC_OR, 5'd2, 5'd1, 5'd8));
        add_entry(enc_3r(la_core_pkg::OPC_XOR, 5'd2, 5'd1, 5'd9));
        add_entry(enc_3r(la_core_pkg::OPC_SLT, 5'd2, 5'd1, 5'd10));
        add_entry(enc_3r(la_core_pkg::OPC_SLT, 5'd1, 5'd2, 5'd11));
        // imm12 bit 11 set on every one of these
        add_entry(enc_2ri12(la_core_pkg::OPC_ORI, 12'hf0f, 5'd0, 5'd13));
        add_entry(enc_2ri12(la_core_pkg::OPC_XORI, 12'hfff, 5'd2, 5'd14));
        add_entry(enc_2ri12(la_core_pkg::OPC_ADDI_W, 12'h800, 5'd1, 5'd15));
        // r15 is negative here so its upper bits are all ones
        add_entry(enc_2ri12(la_core_pkg::OPC_ANDI, 12'h8f0, 5'd15, 5'd12));
        add_entry(enc_2ri12(la_core_pkg::OPC_SLTI, 12'hfff, 5'd0, 5'd16));
        // base address 0x40 in r20
        add_entry(enc_2ri12(la_core_pkg::OPC_ADDI_W, 12'h040, 5'd0, 5'd20));
        add_entry(enc_2ri12(la_core_pkg::OPC_ST_W, 12'd8, 5'd20, 5'd1));
        add_entry(enc_2ri12(la_core_pkg::OPC_LD_W, 12'd8, 5'd20, 5'd21));
        add_entry(enc_2ri14(la_core_pkg::OPC_LL_W, 14'd2, 5'd20, 5'd23));
        add_entry(enc_2ri14(la_core_pkg::OPC_SC_W, 14'd2, 5'd20, 5'd2));
        add_entry(enc_2ri12(la_core_pkg::OPC_LD_W, 12'd8, 5'd20, 5'd24));
        add_entry(enc_2ri14(la_core_pkg::OPC_SC_W, 14'd2, 5'd20, 5'd3));
        add_entry(enc_2ri12(la_core_pkg::OPC_LD_W, 12'd8, 5'd20, 5'd25));
        // a store between LL.W and SC.W breaks the link
        add_entry(enc_2ri12(la_core_pkg::OPC_ST_W, 12'd16, 5'd20, 5'd4));
        add_entry(enc_2ri14(la_core_pkg::OPC_LL_W, 14'd4, 5'd20, 5'd26));
        add_entry(enc_2ri12(la_core_pkg::OPC_ST_W, 12'd24, 5'd20, 5'd5));
        add_entry(enc_2ri14(la_core_pkg::OPC_SC_W, 14'd4, 5'd20, 5'd6));
        add_entry(enc_2ri12(la_core_pkg::OPC_LD_W, 12'd16, 5'd20, 5'd27));
        add_entry(enc_2ri12(la_core_pkg::OPC_LD_W, 12'd24, 5'd20, 5'd28));
        // no decoder claims this word and its rd field is r31
        add_entry(32'hffff_ffff);
        add_entry(enc_3r(la_core_pkg::OPC_ADD_W, 5'd0, 5'd31, 5'd29));
        add_entry(enc_2ri12(la_core_pkg::OPC_ADDI_W, 12'd5, 5'd1, 5'd0));
        add_entry(enc_3r(la_core_pkg::OPC_ADD_W, 5'd0, 5'd0, 5'd30));
    endtask

    task automatic check_retire(input logic            exp_valid,
                                input logic [AW-1:0]   exp_addr,
                                input logic [XLEN-1:0] exp_data);
        if (retire_valid_o !== exp_valid) begin
            $display("[FAIL] retire_valid_o got %h expected %h (cycle %0d)",
                     retire_valid_o, exp_valid, cycle);
            retire_errs++;
        end else if (exp_valid) begin
            if (retire_addr_o !== exp_addr) begin
                $display("[FAIL] retire_addr_o got %h expected %h", retire_addr_o, exp_addr);
                retire_errs++;
            end
            if (retire_data_o !== exp_data) begin
                $display("[FAIL] retire_data_o got %h expected %h", retire_data_o, exp_data);
                retire_errs++;
            end
        end
    endtask

    task automatic check_illegal(input logic exp_illegal);
        if (illegal_o !== exp_illegal) begin
            $display("[FAIL] illegal_o got %h expected %h (cycle %0d)",
                     illegal_o, exp_illegal, cycle);
            illegal_errs++;
        end
    endtask

    // outputs are sampled half a cycle after the edge that updates them
    always @(negedge clk) begin
        logic exp_ret;
        logic exp_ill;
        if (rst_n_i) begin
            exp_ret = ret_due_q.size() > 0 && ret_due_q[0] == cycle;
            exp_ill = ill_due_q.size() > 0 && ill_due_q[0] == cycle;
            if (exp_ret) begin
                check_retire(1'b1, ret_addr_q[0], ret_data_q[0]);
                void'(ret_due_q.pop_front());
                void'(ret_addr_q.pop_front());
                void'(ret_data_q.pop_front());
            end else begin
                check_retire(1'b0, '0, '0);
            end
            if (exp_ill) begin
                void'(ill_due_q.pop_front());
            end
            check_illegal(exp_ill);
        end
    end

    initial begin
        wait (built);
        repeat (tbl_instr.size() * 2 + 20) @(posedge clk);
        $display("timeout: pipeline did not drain within the allowed cycles");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        issue_i      = 1'b0;
        instr_i      = '0;
        cycle        = 0;
        retire_errs  = 0;
        illegal_errs = 0;
        lfsr_state   = 32'h65d0;
        built        = 1'b0;
        build_table();
        built = 1'b1;
        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;
        for (int i = 0; i < tbl_instr.size(); i++) begin
            @(posedge clk);
            issue_i <= 1'b1;
            instr_i <= tbl_instr[i];
            // visible after the third edge following the one that samples it
            if (tbl_wr[i]) begin
                ret_due_q.push_back(cycle + 4);
                ret_addr_q.push_back(tbl_addr[i]);
                ret_data_q.push_back(tbl_data[i]);
            end
            if (tbl_ill[i]) begin
                ill_due_q.push_back(cycle + 4);
            end
            @(posedge clk);
            issue_i <= 1'b0;
        end
        while (ret_due_q.size() > 0 || ill_due_q.size() > 0) begin
            @(negedge clk);
        end
        repeat (2) @(posedge clk);
        $display("errors: %0d retire, %0d illegal", retire_errs, illegal_errs);
        if (retire_errs == 0 && illegal_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: compile.f
la_core_pkg.sv
decode_if.sv
decoder_2ri14.sv
decoder_2ri12.sv
decoder_3r.sv
gpr_file.sv
decode_stage.sv
alu_execute.sv
result_stage.sv
la_exec_top.sv
tb_la_exec_top.sv
